// ==== common/vng_pkg.sv ====
`default_nettype none

package vng_pkg;

    // schedule
    localparam int NUM_PHASES = 12;
    localparam int NB_SLOTS = 8;

    // phase of the per-pixel schedule, 0..NUM_PHASES-1
    typedef logic [3:0] phase_t;

    // number of selected neighbours, 0..NB_SLOTS
    typedef logic [3:0] cnt_t;

    // Q14 reciprocal of the count
    // msb stays clear, the value feeds a signed multiply
    typedef logic [15:0] scale_t;

    // minuend select: 0 red, 1 green, 2 blue
    typedef logic [1:0] a_sel_t;

endpackage

`default_nettype wire

// ==== src/vng_phase_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module vng_phase_counter
    import vng_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   clk_en,
    output phase_t phase
);

    logic wrap;

    assign wrap = (phase == phase_t'(NUM_PHASES - 1));

    // one step per enabled cycle, the whole pipeline keys off this
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (clk_en) begin
            if (wrap) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/vng_neighbor_sum.sv ====
`timescale 1ns/1ps
`default_nettype none

module vng_neighbor_sum
    import vng_pkg::*;
#(
    parameter int data_w = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clk_en,
    input  phase_t            phase,
    input  logic [data_w-1:0] nb_red,
    input  logic [data_w-1:0] nb_green,
    input  logic [data_w-1:0] nb_blue,
    input  logic              nb_sel,
    output logic [data_w+3:0] sum_red,
    output logic [data_w+3:0] sum_green,
    output logic [data_w+3:0] sum_blue,
    output cnt_t              sum_cnt,
    output logic              sums_valid
);

    typedef logic [data_w+3:0] sum_t;

    sum_t acc_red;
    sum_t acc_green;
    sum_t acc_blue;
    cnt_t acc_cnt;
    sum_t add_red;
    sum_t add_green;
    sum_t add_blue;
    sum_t nxt_red;
    sum_t nxt_green;
    sum_t nxt_blue;
    cnt_t nxt_cnt;
    logic accept;
    logic first;
    logic last;

    assign accept = (phase < phase_t'(NB_SLOTS));
    assign first = (phase == '0);
    assign last = (phase == phase_t'(NB_SLOTS - 1));

    // unselected neighbours contribute nothing
    always_comb begin
        add_red = nb_sel ? sum_t'(nb_red) : '0;
        add_green = nb_sel ? sum_t'(nb_green) : '0;
        add_blue = nb_sel ? sum_t'(nb_blue) : '0;
        if (first) begin
            nxt_red = add_red;
            nxt_green = add_green;
            nxt_blue = add_blue;
            nxt_cnt = cnt_t'(nb_sel);
        end else begin
            nxt_red = acc_red + add_red;
            nxt_green = acc_green + add_green;
            nxt_blue = acc_blue + add_blue;
            nxt_cnt = acc_cnt + cnt_t'(nb_sel);
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en && accept) begin
            acc_red <= nxt_red;
            acc_green <= nxt_green;
            acc_blue <= nxt_blue;
            acc_cnt <= nxt_cnt;
            // publish with the last sample folded in
            if (last) begin
                sum_red <= nxt_red;
                sum_green <= nxt_green;
                sum_blue <= nxt_blue;
                sum_cnt <= nxt_cnt;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sums_valid <= 1'b0;
        end else if (clk_en && last) begin
            sums_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== diff/vng_diff_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module vng_diff_ctrl
    import vng_pkg::*;
(
    input  logic   clk,
    input  logic   clk_en,
    input  phase_t phase,
    output a_sel_t diff_a_sel,
    output logic   diff_b_sel,
    output logic   scale_en,
    output logic   mult_en
);

    // entry 11 on the left, entry 0 on the right
    // sums are stable from phase 8, so the muxes run at phases 8, 9 and 10
    // for g-r, b-r and b-g
    localparam a_sel_t [NUM_PHASES-1:0] a_sel_rom = {
        2'd0, 2'd0, 2'd2, 2'd2,
        2'd1, 2'd0, 2'd0, 2'd0,
        2'd0, 2'd0, 2'd0, 2'd0
    };

    // subtrahend green only for b-g
    localparam logic [NUM_PHASES-1:0] b_sel_rom = 12'b0010_0000_0000;

    // reciprocal loads once, right after the publish
    localparam logic [NUM_PHASES-1:0] scale_en_rom = 12'b0000_1000_0000;

    // products of the three differences reach the output register
    // at phases 1, 2 and 3 of the next window
    localparam logic [NUM_PHASES-1:0] mult_en_rom = 12'b0000_0000_0111;

    always_ff @(posedge clk) begin
        if (clk_en) begin
            diff_a_sel <= a_sel_rom[phase];
            diff_b_sel <= b_sel_rom[phase];
            scale_en <= scale_en_rom[phase];
            mult_en <= mult_en_rom[phase];
        end
    end

endmodule

`default_nettype wire

// ==== diff/vng_diff.sv ====
`timescale 1ns/1ps
`default_nettype none

module vng_diff
    import vng_pkg::*;
#(
    parameter int data_w = 8
) (
    input  logic                     clk,
    input  logic                     clk_en,
    input  phase_t                   phase,
    input  logic        [data_w+3:0] sum_red,
    input  logic        [data_w+3:0] sum_green,
    input  logic        [data_w+3:0] sum_blue,
    input  cnt_t                     sum_cnt,
    output logic signed [data_w:0]   diff_norm
);

    typedef logic [data_w+3:0] sum_t;
    typedef logic signed [data_w+4:0] dif_t;
    typedef logic signed [data_w+20:0] prod_t;

    a_sel_t diff_a_sel;
    logic diff_b_sel;
    logic scale_en;
    logic mult_en;

    sum_t diff_a;
    sum_t diff_b;
    dif_t diff;
    scale_t scale;
    dif_t mult_a;
    logic signed [15:0] mult_b;
    prod_t mult_out0;
    prod_t mult_out;

    vng_diff_ctrl u_ctrl (
        .clk        (clk),
        .clk_en     (clk_en),
        .phase      (phase),
        .diff_a_sel (diff_a_sel),
        .diff_b_sel (diff_b_sel),
        .scale_en   (scale_en),
        .mult_en    (mult_en)
    );

    // operand select
    always_ff @(posedge clk) begin
        if (clk_en) begin
            case (diff_a_sel)
                2'd1:    diff_a <= sum_green;
                2'd2:    diff_a <= sum_blue;
                default: diff_a <= sum_red;
            endcase
            diff_b <= diff_b_sel ? sum_green : sum_red;
        end
    end

    // one extra bit holds the sign
    always_ff @(posedge clk) begin
        if (clk_en) begin
            diff <= {1'b0, diff_a} - {1'b0, diff_b};
        end
    end

    // 2**14 / count
    always_ff @(posedge clk) begin
        if (clk_en && scale_en) begin
            case (sum_cnt)
                4'd1:    scale <= 16'd16384;
                4'd2:    scale <= 16'd8192;
                4'd3:    scale <= 16'd5461;
                4'd4:    scale <= 16'd4096;
                4'd5:    scale <= 16'd3276;
                4'd6:    scale <= 16'd2730;
                4'd7:    scale <= 16'd2340;
                4'd8:    scale <= 16'd2048;
                default: scale <= 16'd0;
            endcase
        end
    end

    // registered operands, product, then a second product stage
    // up to three differences are in flight here
    always_ff @(posedge clk) begin
        if (clk_en) begin
            mult_a <= diff;
            mult_b <= scale;
            mult_out0 <= mult_a * mult_b;
            mult_out <= mult_out0;
        end
    end

    // divide by 2**15, the bit select floors toward minus infinity
    always_ff @(posedge clk) begin
        if (clk_en && mult_en) begin
            diff_norm <= mult_out[data_w+15:15];
        end
    end

endmodule

`default_nettype wire

// ==== src/vng_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module vng_collect
    import vng_pkg::*;
#(
    parameter int data_w = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  phase_t                 phase,
    input  logic                   sums_valid,
    input  logic signed [data_w:0] diff_norm,
    output logic signed [data_w:0] diff_gr,
    output logic signed [data_w:0] diff_br,
    output logic signed [data_w:0] diff_bg,
    output logic                   out_valid
);

    // first mux at phase NB_SLOTS, six enabled stages until diff_norm
    // can be captured here
    localparam int cap_first = NB_SLOTS + 6;
    localparam phase_t cap_gr = phase_t'(cap_first % NUM_PHASES);
    localparam phase_t cap_br = phase_t'((cap_first + 1) % NUM_PHASES);
    localparam phase_t cap_bg = phase_t'((cap_first + 2) % NUM_PHASES);
    // publish lands at the phase NB_SLOTS-1 enable, seen one phase later
    localparam phase_t win_ph = phase_t'(NB_SLOTS);

    logic win_valid;
    logic out_valid_q;

    always_ff @(posedge clk) begin
        if (clk_en) begin
            case (phase)
                cap_gr:  diff_gr <= diff_norm;
                cap_br:  diff_br <= diff_norm;
                cap_bg:  diff_bg <= diff_norm;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
            out_valid_q <= 1'b0;
        end else if (clk_en) begin
            if (phase == win_ph) begin
                win_valid <= sums_valid;
            end
            out_valid_q <= (phase == cap_bg) && win_valid;
        end
    end

    // one enabled cycle wide, even across a stall
    assign out_valid = out_valid_q && clk_en;

endmodule

`default_nettype wire

// ==== src/vng_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vng_top
    import vng_pkg::*;
#(
    parameter int data_w = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_en,
    input  logic [data_w-1:0]      nb_red,
    input  logic [data_w-1:0]      nb_green,
    input  logic [data_w-1:0]      nb_blue,
    input  logic                   nb_sel,
    output logic signed [data_w:0] diff_gr,
    output logic signed [data_w:0] diff_br,
    output logic signed [data_w:0] diff_bg,
    output logic                   out_valid
);

    phase_t phase;
    logic [data_w+3:0] sum_red;
    logic [data_w+3:0] sum_green;
    logic [data_w+3:0] sum_blue;
    cnt_t sum_cnt;
    logic sums_valid;
    logic signed [data_w:0] diff_norm;

    vng_phase_counter u_phase (
        .clk    (clk),
        .rst_n  (rst_n),
        .clk_en (clk_en),
        .phase  (phase)
    );

    vng_neighbor_sum #(
        .data_w (data_w)
    ) u_sum (
        .clk        (clk),
        .rst_n      (rst_n),
        .clk_en     (clk_en),
        .phase      (phase),
        .nb_red     (nb_red),
        .nb_green   (nb_green),
        .nb_blue    (nb_blue),
        .nb_sel     (nb_sel),
        .sum_red    (sum_red),
        .sum_green  (sum_green),
        .sum_blue   (sum_blue),
        .sum_cnt    (sum_cnt),
        .sums_valid (sums_valid)
    );

    vng_diff #(
        .data_w (data_w)
    ) u_diff (
        .clk       (clk),
        .clk_en    (clk_en),
        .phase     (phase),
        .sum_red   (sum_red),
        .sum_green (sum_green),
        .sum_blue  (sum_blue),
        .sum_cnt   (sum_cnt),
        .diff_norm (diff_norm)
    );

    vng_collect #(
        .data_w (data_w)
    ) u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .clk_en     (clk_en),
        .phase      (phase),
        .sums_valid (sums_valid),
        .diff_norm  (diff_norm),
        .diff_gr    (diff_gr),
        .diff_br    (diff_br),
        .diff_bg    (diff_bg),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

// ==== tb/tb_vng_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vng_top;

    localparam int data_w = 8;
    // longest clk_en gap, in clock cycles per enabled cycle
    localparam int max_gap = 4;
    localparam int n_windows = 1 + 5 + 29 + 5 + 12 + 40 + 1;
    localparam int watchdog_ns = n_windows * 12 * max_gap * 10 + 2000;

    logic clk;
    logic rst_n;
    logic clk_en;
    logic [data_w-1:0] nb_red;
    logic [data_w-1:0] nb_green;
    logic [data_w-1:0] nb_blue;
    logic nb_sel;
    logic signed [data_w:0] diff_gr;
    logic signed [data_w:0] diff_br;
    logic signed [data_w:0] diff_bg;
    logic out_valid;

    logic [31:0] rng_state = 32'd19;
    logic [7:0] win_red [8];
    logic [7:0] win_green [8];
    logic [7:0] win_blue [8];
    logic [7:0] win_sel;
    int en_count = 0;
    int last_pulse = 0;
    int pulses = 0;
    int windows_sent = 0;
    string exp_name [$];
    int exp_gr [$];
    int exp_br [$];
    int exp_bg [$];

    vng_top #(
        .data_w (data_w)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .nb_red    (nb_red),
        .nb_green  (nb_green),
        .nb_blue   (nb_blue),
        .nb_sel    (nb_sel),
        .diff_gr   (diff_gr),
        .diff_br   (diff_br),
        .diff_bg   (diff_bg),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int recip_q14(input int cnt);
        case (cnt)
            1: return 16384;
            2: return 8192;
            3: return 5461;
            4: return 4096;
            5: return 3276;
            6: return 2730;
            7: return 2340;
            8: return 2048;
            default: return 0;
        endcase
    endfunction

    function automatic int norm_diff(input int a, input int b, input int cnt);
        int prod;
        prod = (a - b) * recip_q14(cnt);
        // arithmetic shift floors toward minus infinity
        return prod >>> 15;
    endfunction

    function automatic logic [7:0] pick_mask(input int k);
        logic [7:0] m;
        logic [31:0] v;
        m = '0;
        while ($countones(m) < k) begin
            v = next_rand();
            m[v[2:0]] = 1'b1;
        end
        return m;
    endfunction

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic fail_with(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input string field, input int exp,
                                   input int act);
        $display("CHECK FAILED test=%s %s expected=%0d actual=%0d", name, field, exp, act);
        stop_run();
    endtask

    task automatic set_junk();
        logic [31:0] v;
        v = next_rand();
        nb_red = v[7:0];
        nb_green = v[15:8];
        nb_blue = v[23:16];
        nb_sel = v[24];
    endtask

    // optional stall, then one enabled cycle carrying the given sample
    task automatic drive_cycle(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b,
                               input logic sel, input bit stalls);
        logic [31:0] v;
        int gap;
        gap = 0;
        if (stalls) begin
            v = next_rand();
            gap = v[2] ? int'(v[1:0]) : 0;
        end
        repeat (gap) begin
            clk_en = 1'b0;
            set_junk();
            @(posedge clk);
            #1;
        end
        clk_en = 1'b1;
        nb_red = r;
        nb_green = g;
        nb_blue = b;
        nb_sel = sel;
        @(posedge clk);
        #1;
    endtask

    task automatic fill_const(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b,
                              input logic [7:0] mask);
        for (int i = 0; i < 8; i++) begin
            win_red[i] = r;
            win_green[i] = g;
            win_blue[i] = b;
        end
        win_sel = mask;
    endtask

    task automatic fill_random(input logic [7:0] mask);
        logic [31:0] v;
        for (int i = 0; i < 8; i++) begin
            v = next_rand();
            win_red[i] = v[7:0];
            win_green[i] = v[15:8];
            win_blue[i] = v[23:16];
        end
        win_sel = mask;
    endtask

    // eight neighbour phases from the window arrays, four ignored phases of noise
    task automatic run_window(input string name, input bit stalls);
        int s_r;
        int s_g;
        int s_b;
        int cnt;
        logic [31:0] v;
        s_r = 0;
        s_g = 0;
        s_b = 0;
        cnt = 0;
        for (int i = 0; i < 8; i++) begin
            if (win_sel[i]) begin
                s_r += win_red[i];
                s_g += win_green[i];
                s_b += win_blue[i];
                cnt++;
            end
            drive_cycle(win_red[i], win_green[i], win_blue[i], win_sel[i], stalls);
        end
        exp_name.push_back(name);
        exp_gr.push_back(norm_diff(s_g, s_r, cnt));
        exp_br.push_back(norm_diff(s_b, s_r, cnt));
        exp_bg.push_back(norm_diff(s_b, s_g, cnt));
        windows_sent++;
        for (int i = 8; i < 12; i++) begin
            v = next_rand();
            drive_cycle(v[7:0], v[15:8], v[23:16], v[24], stalls);
        end
    endtask

    task automatic check_pulse();
        string name;
        int e_gr;
        int e_br;
        int e_bg;
        int a_gr;
        int a_br;
        int a_bg;
        if (exp_name.size() == 0) begin
            fail_with("out_valid with empty expectation queue");
        end else begin
            name = exp_name.pop_front();
            e_gr = exp_gr.pop_front();
            e_br = exp_br.pop_front();
            e_bg = exp_bg.pop_front();
            a_gr = diff_gr;
            a_br = diff_br;
            a_bg = diff_bg;
            assert (a_gr == e_gr) else report_mismatch(name, "diff_gr", e_gr, a_gr);
            assert (a_br == e_br) else report_mismatch(name, "diff_br", e_br, a_br);
            assert (a_bg == e_bg) else report_mismatch(name, "diff_bg", e_bg, a_bg);
        end
    endtask

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else fail_with("out_valid high during reset");

    pulse_needs_enable: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> clk_en)
        else fail_with("out_valid high while clk_en is low");

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n && clk_en) begin
            en_count = en_count + 1;
            if (out_valid) begin
                if (pulses == 0) begin
                    assert (en_count > 12 && en_count <= 24)
                        else fail_with($sformatf("first out_valid at enabled cycle %0d",
                                                 en_count));
                end else begin
                    assert (en_count - last_pulse == 12)
                        else fail_with($sformatf("out_valid %0d enabled cycles after the last",
                                                 en_count - last_pulse));
                end
                last_pulse = en_count;
                pulses = pulses + 1;
                check_pulse();
            end
        end
    end

    initial begin
        #(watchdog_ns);
        fail_with($sformatf("timeout with %0d results still missing", exp_name.size()));
    end

    initial begin
        logic [31:0] v;
        logic [31:0] data_state;
        logic [31:0] start_state;
        string name;
        int i;
        int k;
        rst_n = 1'b0;
        clk_en = 1'b0;
        nb_red = '0;
        nb_green = '0;
        nb_blue = '0;
        nb_sel = 1'b0;
        @(posedge clk);
        #1;
        clk_en = 1'b1;
        repeat (3) begin
            set_junk();
            @(posedge clk);
            #1;
        end
        rst_n = 1'b1;

        fill_random(8'hff);
        run_window("reset_start", 1'b0);

        fill_const(8'd100, 8'd50, 8'd200, 8'hff);
        run_window("full_select", 1'b0);
        fill_const(8'd10, 8'd200, 8'd30, 8'hff);
        run_window("full_select", 1'b0);
        fill_const(8'd255, 8'd0, 8'd128, 8'hff);
        run_window("full_select", 1'b0);
        fill_const(8'd7, 8'd7, 8'd7, 8'hff);
        run_window("full_select", 1'b0);
        fill_const(8'd0, 8'd1, 8'd2, 8'hff);
        run_window("full_select", 1'b0);

        for (k = 0; k <= 8; k++) begin
            fill_random(pick_mask(k));
            run_window("partial_count", 1'b0);
        end
        for (i = 0; i < 20; i++) begin
            v = next_rand();
            fill_random(v[7:0]);
            run_window("partial_count", 1'b0);
        end

        fill_const(8'd0, 8'd255, 8'd255, 8'hff);
        run_window("extremes", 1'b0);
        fill_const(8'd255, 8'd0, 8'd0, 8'hff);
        run_window("extremes", 1'b0);
        fill_const(8'd0, 8'd255, 8'd0, 8'hff);
        run_window("extremes", 1'b0);
        fill_const(8'd0, 8'd255, 8'd255, 8'h01);
        run_window("extremes", 1'b0);
        fill_const(8'd255, 8'd0, 8'd0, 8'h80);
        run_window("extremes", 1'b0);

        // same six windows twice, the second pass with clk_en gaps
        start_state = rng_state;
        for (k = 0; k < 2; k++) begin
            data_state = start_state;
            if (k == 0) begin
                name = "stall_ref";
            end else begin
                name = "stall";
            end
            for (i = 0; i < 6; i++) begin
                rng_state = data_state;
                v = next_rand();
                fill_random(v[7:0]);
                data_state = rng_state;
                run_window(name, k == 1);
            end
        end

        for (i = 0; i < 40; i++) begin
            v = next_rand();
            fill_random(v[7:0]);
            run_window("throughput", 1'b0);
        end

        // flush so the last window's results come out
        for (i = 0; i < 12; i++) begin
            v = next_rand();
            drive_cycle(v[7:0], v[15:8], v[23:16], 1'b0, 1'b0);
        end
        clk_en = 1'b0;
        repeat (4) @(posedge clk);

        if (exp_name.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_with($sformatf("%0d of %0d windows gave no result",
                                windows_sent - pulses, windows_sent));
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/vng_pkg.sv
src/vng_phase_counter.sv
src/vng_neighbor_sum.sv
diff/vng_diff_ctrl.sv
diff/vng_diff.sv
src/vng_collect.sv
src/vng_top.sv
tb/tb_vng_top.sv
